// ==== aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit
(
    input  mipsCorePkg::wordT  a,
    input  mipsCorePkg::wordT  b,
    input  mipsIsaPkg::aluOpT  op,
    output mipsCorePkg::wordT  result,
    output logic               zero
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    always_comb
    begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluXor:  result = a ^ b;
            aluSlt:  result = ($signed(a) < $signed(b)) ? wordT'(1) : '0;
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);   // bne branches when this is low.

endmodule

// ==== control.sv ====
`timescale 1ns/1ns

module control
(
    input mipsIsaPkg::opcodeT opcode,
    input mipsIsaPkg::functT  funct,
    ctrlIf.decoder            ctrl
);
    import mipsIsaPkg::*;

    always_comb
    begin
        ctrl.regDst   = 1'b0;   // everything inactive unless decoded below.
        ctrl.jump     = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memtoReg = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.aluOp    = aluAdd;

        case (opcode)
            opJump:
            begin
                ctrl.jump = 1'b1;
            end
            opJal:
            begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;   // link register gets PC+4.
            end
            opLw:
            begin
                ctrl.memRead  = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.aluSrc   = 1'b1;   // address is base plus offset.
                ctrl.regWrite = 1'b1;
            end
            opSw:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opBne:
            begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;   // operands differ when the difference is nonzero.
            end
            opXori:
            begin
                ctrl.aluOp    = aluXor;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opRtype:
            begin
                case (funct)
                    fnJr:
                    begin
                        ctrl.regDst  = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    fnAdd, fnSub, fnSlt:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = (funct == fnAdd) ? aluAdd :
                                        (funct == fnSub) ? aluSub : aluSlt;
                    end
                    default:
                    begin
                        ctrl.aluOp = aluAdd;    // unknown funct runs as a no-op.
                    end
                endcase
            end
            default:
            begin
                ctrl.aluOp = aluAdd;    // unknown opcode runs as a no-op.
            end
        endcase
    end

endmodule

// ==== ctrlIf.sv ====
`timescale 1ns/1ns

interface ctrlIf;
    import mipsIsaPkg::*;

    logic  regDst;
    logic  jump;
    logic  branch;
    logic  memRead;
    logic  memtoReg;
    logic  memWrite;
    logic  aluSrc;
    logic  regWrite;
    logic  jumpReg;
    aluOpT aluOp;

    modport decoder
    (
        output regDst, jump, branch, memRead, memtoReg,
        output memWrite, aluSrc, regWrite, jumpReg, aluOp
    );

    modport datapath
    (
        input regDst, jump, branch, memRead, memtoReg,
        input memWrite, aluSrc, regWrite, jumpReg, aluOp
    );

endinterface

// ==== mipsCore.f ====
mipsIsaPkg.sv
mipsCorePkg.sv
ctrlIf.sv
control.sv
aluUnit.sv
regFile.sv
pcUnit.sv
mipsCore.sv
mipsCore_sva.sv
mipsCore_tb.sv

// ==== mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore
#(
    parameter mipsCorePkg::wordT resetPc = '0
)
(
    input  logic              clk,
    input  logic              rstN,
    output mipsCorePkg::wordT instrAddr,
    input  mipsCorePkg::wordT instr,
    output mipsCorePkg::wordT dataAddr,
    output mipsCorePkg::wordT dataWrData,
    output logic              dataWe,
    output logic              dataRe,
    input  mipsCorePkg::wordT dataRdData
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    opcodeT      opcode;
    functT       funct;
    regIdxT      rs;
    regIdxT      rt;
    regIdxT      rd;
    logic [15:0] imm;
    logic [25:0] target;
    wordT        rsData;
    wordT        rtData;
    wordT        immExt;
    wordT        aluB;
    wordT        aluResult;
    wordT        pcPlus4;
    wordT        wbData;
    regIdxT      wrIdx;
    logic        aluZero;
    logic        isLink;
    logic        regWe;

    ctrlIf ctrlBus ();

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    assign isLink = (opcode == opJal);

    // loads and stores sign-extend their offset, xori zero-extends.
    assign immExt = (ctrlBus.memRead || ctrlBus.memWrite) ?
                    {{(wordWidth - 16){imm[15]}}, imm} : {{(wordWidth - 16){1'b0}}, imm};
    assign aluB   = ctrlBus.aluSrc ? immExt : rtData;

    assign wrIdx  = isLink ? linkReg : (ctrlBus.regDst ? rd : rt);
    assign wbData = isLink ? pcPlus4 : (ctrlBus.memtoReg ? dataRdData : aluResult);
    assign regWe  = ctrlBus.regWrite & rstN;

    assign dataAddr   = aluResult;
    assign dataWrData = rtData;
    assign dataWe     = ctrlBus.memWrite & rstN;  // no memory traffic while in reset.
    assign dataRe     = ctrlBus.memRead & rstN;

    control uControl
    (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrlBus.decoder)
    );

    regFile uRegFile
    (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rs),
        .rdAddrB (rt),
        .wrAddr  (wrIdx),
        .wrEn    (regWe),
        .wrData  (wbData),
        .rdDataA (rsData),
        .rdDataB (rtData)
    );

    aluUnit uAlu
    (
        .a      (rsData),
        .b      (aluB),
        .op     (ctrlBus.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    pcUnit #(.resetPc(resetPc)) uPc
    (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrlBus.datapath),
        .aluZero   (aluZero),
        .immediate (imm),
        .target    (target),
        .regTarget (rsData),
        .pc        (instrAddr),
        .pcPlus4   (pcPlus4)
    );

endmodule

// ==== mipsCorePkg.sv ====
package mipsCorePkg;

    parameter int wordWidth = 32;   // data and address width.
    parameter int regCount = 32;    // number of general registers.

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [4:0] regIdxT;

    parameter regIdxT zeroReg = 5'd0;   // hardwired zero register.
    parameter regIdxT linkReg = 5'd31;  // return address written by jal.

endpackage

// ==== mipsCore_sva.sv ====
`timescale 1ns/1ns

module mipsCore_sva
#(
    parameter mipsCorePkg::wordT resetPc = '0
)
(
    input logic              clk,
    input logic              rstN,
    input mipsCorePkg::wordT instrAddr,
    input logic              dataWe,
    input logic              dataRe
);

    int failures = 0;   // number of failed checks.

    noLoadAndStore: assert property (@(posedge clk) !(dataWe && dataRe))
        else
        begin
            failures++;
            $error("load and store requested in the same cycle");
        end

    alignedFetch: assert property (@(posedge clk) instrAddr[1:0] == 2'b00)
        else
        begin
            failures++;
            $error("instruction address %h is not word aligned", instrAddr);
        end

    // the PC register is cleared asynchronously, so it must already sit at resetPc.
    resetFetch: assert property (@(posedge clk) !rstN |-> instrAddr == resetPc)
        else
        begin
            failures++;
            $error("instruction address %h left the reset address in reset", instrAddr);
        end

    resetNoStore: assert property (@(posedge clk) !rstN |-> !dataWe)
        else
        begin
            failures++;
            $error("store issued while in reset");
        end

endmodule

bind mipsCore mipsCore_sva #(.resetPc(resetPc)) sva
(
    .clk       (clk),
    .rstN      (rstN),
    .instrAddr (instrAddr),
    .dataWe    (dataWe),
    .dataRe    (dataRe)
);

// ==== mipsCore_tb.sv ====
`timescale 1ns/1ns

module mipsCore_tb;
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    localparam wordT resetPc = 32'h0000_0040;
    localparam int maxCycles = 6 * 40 * 2;

    logic clk = 1'b1;
    logic rstN = 1'b1;
    wordT instrAddr, instr, dataAddr, dataWrData, dataRdData, pcOffset, haltAddr, ea, ed;
    logic dataWe, dataRe;
    wordT imem [128];
    wordT dmem [256];
    wordT expAddrQ [$];
    wordT expDataQ [$];
    wordT opA [8];
    wordT opB [8];
    int asmIdx, cycles, errCount, errAtStart, passCount, failCount;

    mipsCore #(.resetPc(resetPc)) uut (.*);

    always #10 clk = ~clk;

    assign pcOffset = instrAddr - resetPc;
    assign instr = imem[pcOffset[8:2]];
    assign dataRdData = dataRe ? dmem[dataAddr[9:2]] : '0;  // read data only during a load.

    function automatic wordT fill(int i);
        return (i * 32'h9E37_79B1) ^ 32'h5A5A_0000;  // differs in every address bit.
    endfunction

    // a negative word is below any non-negative one, and equal signs compare as unsigned.
    function automatic wordT lessThan(wordT a, wordT b);
        if (a[wordWidth-1] != b[wordWidth-1])
            return wordT'(a[wordWidth-1]);
        return (a < b) ? 32'd1 : 32'd0;
    endfunction

    function automatic int errorTotal();
        return errCount + uut.sva.failures;
    endfunction

    function automatic wordT rType(functT fn, regIdxT s, regIdxT t, regIdxT d);
        return {opRtype, s, t, d, 5'd0, fn};
    endfunction

    function automatic wordT iType(opcodeT op, regIdxT s, regIdxT t, logic [15:0] im);
        return {op, s, t, im};
    endfunction

    function automatic wordT jType(opcodeT op, wordT addr);
        return {op, addr[27:2]};
    endfunction

    task automatic emit(wordT w);
        imem[asmIdx] = w;
        asmIdx++;
    endtask

    task automatic halt();
        haltAddr = resetPc + 4 * asmIdx;
        emit(jType(opJump, haltAddr));  // jump to itself ends the program.
    endtask

    task automatic expectStore(wordT addr, wordT data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    task automatic startTest();
        @(negedge clk);
        rstN = 1'b0;
        asmIdx = 0;
        errAtStart = errorTotal();
        expAddrQ.delete();
        expDataQ.delete();
        for (int i = 0; i < 128; i++)
            imem[i] = '0;
        for (int i = 0; i < 256; i++)
            dmem[i] = fill(i);
    endtask

    task automatic runTest(string name);
        repeat (4) @(negedge clk);
        assert (instrAddr == resetPc) else
        begin
            errCount++;
            $display("Error: time %0t, instrAddr expected %h, actual %h",
                     $time, resetPc, instrAddr);
        end
        rstN = 1'b1;
        do @(negedge clk); while (instrAddr != haltAddr);
        assert (expAddrQ.size() == 0) else
        begin
            errCount++;
            $display("%0d expected stores never happened", expAddrQ.size());
        end
        if (errorTotal() == errAtStart)
            passCount++;
        else
            failCount++;
        $display("%s: %s", name, (errorTotal() == errAtStart) ? "passed" : "failed");
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= maxCycles)
        begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
        else if (dataWe)
        begin
            assert (expAddrQ.size() != 0) else
            begin
                errCount++;
                $display("store to %h at %0t was not expected", dataAddr, $time);
            end
            if (expAddrQ.size() != 0)
            begin
                ea = expAddrQ.pop_front();
                ed = expDataQ.pop_front();
                assert (dataAddr == ea) else
                begin
                    errCount++;
                    $display("Error: time %0t, dataAddr expected %h, actual %h",
                             $time, ea, dataAddr);
                end
                assert (dataWrData == ed) else
                begin
                    errCount++;
                    $display("Error: time %0t, dataWrData expected %h, actual %h",
                             $time, ed, dataWrData);
                end
            end
            dmem[dataAddr[9:2]] <= dataWrData;
        end
    end

    initial
    begin
        void'($urandom(57));
        startTest();
        halt();
        runTest("reset");

        startTest();
        emit(iType(opXori, 0, 1, 16'h0007));
        emit(iType(opXori, 0, 2, 16'hFFF0));    // zero-extended, stays positive.
        emit(rType(fnSub, 0, 1, 3));            // r3 = -7.
        emit(rType(fnAdd, 1, 2, 4));
        emit(iType(opSw, 0, 4, 16'd0));
        emit(rType(fnSub, 1, 2, 5));
        emit(iType(opSw, 0, 5, 16'd4));
        emit(rType(fnSlt, 3, 1, 6));
        emit(iType(opSw, 0, 6, 16'd8));
        emit(rType(fnSlt, 1, 3, 7));
        emit(iType(opSw, 0, 7, 16'd12));
        emit(iType(opXori, 2, 8, 16'h00FF));
        emit(iType(opSw, 0, 8, 16'd16));
        emit(rType(fnAdd, 1, 2, 0));
        emit(iType(opSw, 0, 0, 16'd20));
        halt();
        expectStore(0, 32'd7 + 32'hFFF0);
        expectStore(4, 32'd7 - 32'hFFF0);
        expectStore(8, lessThan(-32'sd7, 32'd7));
        expectStore(12, lessThan(32'd7, -32'sd7));
        expectStore(16, 32'hFFF0 ^ 32'h00FF);
        expectStore(20, 0);
        runTest("arithmetic");

        startTest();
        emit(iType(opXori, 0, 1, 16'h0040));
        emit(iType(opLw, 1, 2, 16'd8));
        emit(iType(opLw, 1, 3, 16'hFFF8));      // offset -8.
        emit(rType(fnAdd, 2, 3, 4));
        emit(iType(opSw, 0, 4, 16'h0080));
        halt();
        expectStore(32'h80, fill(32'h48 >> 2) + fill(32'h38 >> 2));
        runTest("load-use");

        startTest();
        emit(iType(opXori, 0, 1, 16'd1));
        emit(iType(opXori, 0, 2, 16'd2));
        emit(iType(opBne, 1, 2, 16'd1));
        emit(iType(opSw, 0, 1, 16'h10));
        emit(iType(opBne, 1, 1, 16'd1));
        emit(iType(opSw, 0, 2, 16'h14));
        halt();
        expectStore(32'h14, 2);
        runTest("branch");

        startTest();
        emit(iType(opXori, 0, 1, 16'd5));
        emit(jType(opJump, resetPc + 12));
        emit(iType(opSw, 0, 1, 16'h20));
        emit(jType(opJal, resetPc + 24));
        emit(iType(opSw, 0, 1, 16'h24));
        halt();
        emit(iType(opSw, 0, 31, 16'h28));
        emit(rType(fnJr, 31, 0, 0));
        expectStore(32'h28, resetPc + 16);
        expectStore(32'h24, 5);
        runTest("jumps");

        startTest();
        for (int k = 0; k < 8; k++)
        begin
            opA[k] = $urandom();
            opB[k] = $urandom();
            dmem[(32'h200 + 8 * k) >> 2] = opA[k];
            dmem[(32'h204 + 8 * k) >> 2] = opB[k];
            emit(iType(opLw, 0, 1, 16'(32'h200 + 8 * k)));
            emit(iType(opLw, 0, 2, 16'(32'h204 + 8 * k)));
            emit(rType(fnAdd, 1, 2, 3));
            emit(rType(fnSub, 1, 2, 4));
            emit(rType(fnSlt, 1, 2, 5));
            emit(iType(opSw, 0, 3, 16'(32'h300 + 12 * k)));
            emit(iType(opSw, 0, 4, 16'(32'h304 + 12 * k)));
            emit(iType(opSw, 0, 5, 16'(32'h308 + 12 * k)));
            expectStore(32'h300 + 12 * k, opA[k] + opB[k]);
            expectStore(32'h304 + 12 * k, opA[k] - opB[k]);
            expectStore(32'h308 + 12 * k, lessThan(opA[k], opB[k]));
        end
        halt();
        runTest("random operands");

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 passCount, failCount, errorTotal());
        if (failCount == 0 && errorTotal() == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== mipsIsaPkg.sv ====
package mipsIsaPkg;

    // primary opcode, instruction bits 31:26.
    typedef enum logic [5:0]
    {
        opRtype = 6'h00,
        opJump  = 6'h02,
        opJal   = 6'h03,
        opBne   = 6'h05,
        opXori  = 6'h0e,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // function field of R-type instructions, bits 5:0.
    typedef enum logic [5:0]
    {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnSlt = 6'h2a
    } functT;

    // ALU operation codes as produced by the main decoder.
    typedef enum logic [2:0]
    {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluXor = 3'd6,
        aluSlt = 3'd7
    } aluOpT;

endpackage

// ==== pcUnit.sv ====
`timescale 1ns/1ns

module pcUnit
#(
    parameter mipsCorePkg::wordT resetPc = '0
)
(
    input  logic              clk,
    input  logic              rstN,
    ctrlIf.datapath           ctrl,
    input  logic              aluZero,
    input  logic [15:0]       immediate,
    input  logic [25:0]       target,
    input  mipsCorePkg::wordT regTarget,
    output mipsCorePkg::wordT pc,
    output mipsCorePkg::wordT pcPlus4
);
    import mipsCorePkg::*;

    wordT branchOffset;
    wordT pcNext;

    assign pcPlus4 = pc + wordT'(4);
    assign branchOffset = {{(wordWidth - 18){immediate[15]}}, immediate, 2'b00};

    always_comb
    begin
        if (ctrl.jumpReg)
            pcNext = regTarget;
        else if (ctrl.jump)
            pcNext = {pcPlus4[wordWidth-1:wordWidth-4], target, 2'b00};
        else if (ctrl.branch && !aluZero)
            pcNext = pcPlus4 + branchOffset;    // offset counts from the next instruction.
        else
            pcNext = pcPlus4;
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            pc <= resetPc;
        else
            pc <= pcNext;
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile
(
    input  logic                clk,
    input  logic                rstN,
    input  mipsCorePkg::regIdxT rdAddrA,
    input  mipsCorePkg::regIdxT rdAddrB,
    input  mipsCorePkg::regIdxT wrAddr,
    input  logic                wrEn,
    input  mipsCorePkg::wordT   wrData,
    output mipsCorePkg::wordT   rdDataA,
    output mipsCorePkg::wordT   rdDataB
);
    import mipsCorePkg::*;

    wordT regs [regCount];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && (wrAddr != zeroReg))
        begin
            regs[wrAddr] <= wrData;  // writes to register 0 are dropped.
        end
    end

    // reads are combinational, so a value written this cycle shows up next cycle.
    assign rdDataA = (rdAddrA == zeroReg) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == zeroReg) ? '0 : regs[rdAddrB];

endmodule
